//--- flist.f
+incdir+verification
hdl/video_pkg.sv
hdl/filter_pkg.sv
hdl/line_buffer.sv
hdl/gaussian_blur.sv
hdl/blur_output_stage.sv
hdl/blur_top.sv
verification/blur_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the blur testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module blur_tb -f flist.f \
    && ./obj_dir/Vblur_tb | tee /dev/stderr | grep -x "Done: no errors" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/blur_model.svh
// reference image generator and 3x3 gaussian blur model used by the testbench

`ifndef BLUR_MODEL_SVH
`define BLUR_MODEL_SVH

typedef enum logic [1:0] {
    PAT_CONST,
    PAT_HRAMP,
    PAT_CHECKER,
    PAT_RANDOM
} pattern_t;

// current test image, indexed by row then column
logic [PIXEL_WIDTH-1:0] image [V_ACTIVE][H_ACTIVE];

task automatic build_image(input pattern_t kind, input logic [PIXEL_WIDTH-1:0] value);
    for (int v = 0; v < V_ACTIVE; v++) begin
        for (int h = 0; h < H_ACTIVE; h++) begin
            case (kind)
                PAT_CONST:   image[v][h] = value;
                // steep ramp across the row, small offset per row
                PAT_HRAMP:   image[v][h] = PIXEL_WIDTH'(int'(value) + h * 16 + v);
                PAT_CHECKER: image[v][h] = ((h + v) % 2 == 1) ? value : ~value;
                default:     image[v][h] = PIXEL_WIDTH'($urandom_range(255, 0));
            endcase
        end
    end
endtask

// centre tap 4, edge taps 2, corners 1
function automatic int kernel_weight(input int dx, input int dy);
    return ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
endfunction

// expected output for the centre at column h, row v
function automatic int expected_pixel(input int h, input int v);
    int sum;
    if (h == 0 || v == 0) begin
        return int'(image[v][h]);
    end
    sum = 0;
    for (int dy = -1; dy <= 1; dy++) begin
        for (int dx = -1; dx <= 1; dx++) begin
            sum += kernel_weight(dx, dy) * int'(image[v + dy][h + dx]);
        end
    end
    // weights total 16, result rounds down
    return sum / 16;
endfunction

`endif

//--- verification/blur_tb.sv
// blur testbench: clock, reset, stimulus table loop, output monitor, checks and timeout

`timescale 1ns/10ps

module blur_tb import video_pkg::*, filter_pkg::*;;

    localparam int CLK_HALF = 50;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 3;
    localparam int unsigned RNG_SEED = 32'he73a_4944;
    // line buffer register, filter pipeline, output register
    localparam int PIPE_DELAY = BLUR_LATENCY + 2;
    localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;
    localparam int FRAME_OUTPUTS = (H_ACTIVE - 1) * (V_ACTIVE - 1);
    // reset lands in the middle of a row, halfway down the frame
    localparam int PARTIAL_PIXELS = (V_ACTIVE / 2) * H_ACTIVE + H_ACTIVE / 2;
    localparam int NUM_ROWS = 9;

    logic                    clk_in;
    logic                    rst_in;
    logic [PIXEL_WIDTH-1:0]  pixel;
    logic                    pixel_valid;
    logic [HCOUNT_WIDTH-1:0] hcount;
    logic [VCOUNT_WIDTH-1:0] vcount;
    logic [PIXEL_WIDTH-1:0]  blur_pixel;
    logic                    blur_valid;
    logic [HCOUNT_WIDTH-1:0] blur_hcount;
    logic [VCOUNT_WIDTH-1:0] blur_vcount;

    `include "blur_model.svh"

    typedef struct packed {
        pattern_t               kind;
        logic [PIXEL_WIDTH-1:0] value;
        bit                     random_gaps;
        bit                     mid_reset;
        int                     outputs;
    } stim_row_t;

    typedef struct packed {
        int value;
        int col;
        int row;
        int due;
    } expected_t;

    // pattern, value, random gaps, mid-frame reset, outputs per frame
    stim_row_t stim_table [NUM_ROWS] = '{
        '{PAT_CONST,   8'h5a, 1'b0, 1'b0, FRAME_OUTPUTS},
        '{PAT_CONST,   8'hff, 1'b1, 1'b0, FRAME_OUTPUTS},
        '{PAT_HRAMP,   8'h03, 1'b0, 1'b0, FRAME_OUTPUTS},
        '{PAT_CHECKER, 8'hc3, 1'b0, 1'b0, FRAME_OUTPUTS},
        '{PAT_CHECKER, 8'hf0, 1'b1, 1'b0, FRAME_OUTPUTS},
        '{PAT_RANDOM,  8'h00, 1'b1, 1'b0, FRAME_OUTPUTS},
        '{PAT_RANDOM,  8'h00, 1'b0, 1'b1, FRAME_OUTPUTS},
        '{PAT_HRAMP,   8'h40, 1'b1, 1'b1, FRAME_OUTPUTS},
        '{PAT_RANDOM,  8'h00, 1'b0, 1'b0, FRAME_OUTPUTS}
    };

    expected_t   expected_q [$];
    expected_t   popped;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    int          last_due = 0;
    int          out_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    blur_top u_blur_top (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .hcount      (hcount),
        .vcount      (vcount),
        .blur_pixel  (blur_pixel),
        .blur_valid  (blur_valid),
        .blur_hcount (blur_hcount),
        .blur_vcount (blur_vcount)
    );

    always #CLK_HALF clk_in = ~clk_in;

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input int actual, input int expected, input string what);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    function automatic int table_pixel_total();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += FRAME_PIXELS;
            if (stim_table[r].mid_reset) begin
                total += PARTIAL_PIXELS;
            end
        end
        return total;
    endfunction

    // one strobe, then gap idle cycles
    task automatic drive_pixel(input int h, input int v, input int gap);
        expected_t entry;
        @(posedge clk_in);
        #DRIVE_DELAY;
        pixel       = image[v][h];
        pixel_valid = 1'b1;
        hcount      = HCOUNT_WIDTH'(h);
        vcount      = VCOUNT_WIDTH'(v);
        if (h >= 1 && v >= 1) begin
            entry.value = expected_pixel(h - 1, v - 1);
            entry.col   = h - 1;
            entry.row   = v - 1;
            entry.due   = cycle_count + PIPE_DELAY;
            last_due    = entry.due;
            expected_q.push_back(entry);
        end
        repeat (gap) begin
            @(posedge clk_in);
            #DRIVE_DELAY;
            pixel_valid = 1'b0;
        end
    endtask

    task automatic stream_pixels(input bit random_gaps, input int count);
        int gap;
        for (int idx = 0; idx < count; idx++) begin
            gap = random_gaps ? int'($urandom_range(3, 0)) : 0;
            drive_pixel(idx % H_ACTIVE, idx / H_ACTIVE, gap);
        end
        @(posedge clk_in);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
    endtask

    task automatic apply_mid_reset();
        @(posedge clk_in);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
        rst_in      = 1'b1;
        // first reset edge clears every valid in the pipeline
        @(posedge clk_in);
        #DRIVE_DELAY;
        expected_q.delete();
        out_count = 0;
        repeat (RESET_CYCLES - 1) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;
    endtask

    // wait for the last outputs, bounded by the latest due cycle
    task automatic finish_frame(input int r);
        while (expected_q.size() != 0 && cycle_count <= last_due + 2) begin
            @(posedge clk_in);
        end
        if (expected_q.size() != 0) begin
            $display("frame %0d: %0d expected outputs never appeared", r, expected_q.size());
            error_count++;
            expected_q.delete();
        end
        if (out_count != stim_table[r].outputs) begin
            $display("frame %0d: produced %0d outputs but %0d were expected",
                     r, out_count, stim_table[r].outputs);
            error_count++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_in) begin
        if (blur_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("unexpected output at %0t: blur_valid with nothing pending %s",
                         $time, $sformatf("(col %0d row %0d)", blur_hcount, blur_vcount));
                error_count++;
            end else begin
                popped = expected_q.pop_front();
                check_value(int'(blur_pixel), popped.value,
                            $sformatf("pixel at col %0d row %0d", popped.col, popped.row));
                check_value(int'(blur_hcount), popped.col, "output column");
                check_value(int'(blur_vcount), popped.row, "output row");
                check_value(cycle_count, popped.due, "output cycle");
                out_count++;
            end
        end
    end

    initial begin : watchdog
        wait (timeout_limit != 0);
        wait (cycle_count >= timeout_limit);
        $display("timeout: run did not finish within %0d clock cycles", timeout_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(RNG_SEED));
        clk_in      = 1'b0;
        rst_in      = 1'b1;
        pixel       = '0;
        pixel_valid = 1'b0;
        hcount      = '0;
        vcount      = '0;
        timeout_limit = table_pixel_total() * 4 + 100;

        repeat (RESET_CYCLES) @(posedge clk_in);
        #DRIVE_DELAY;
        rst_in = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            build_image(stim_table[r].kind, stim_table[r].value);
            if (stim_table[r].mid_reset) begin
                stream_pixels(stim_table[r].random_gaps, PARTIAL_PIXELS);
                apply_mid_reset();
            end
            out_count = 0;
            stream_pixels(stim_table[r].random_gaps, FRAME_PIXELS);
            finish_frame(r);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- hdl/blur_top.sv
// blur_top: streaming 3x3 gaussian blur built from line buffer, filter and output stage

`timescale 1ns/10ps

module blur_top import video_pkg::*; (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic [PIXEL_WIDTH-1:0]  pixel,
    input  logic                    pixel_valid,
    input  logic [HCOUNT_WIDTH-1:0] hcount,
    input  logic [VCOUNT_WIDTH-1:0] vcount,
    output logic [PIXEL_WIDTH-1:0]  blur_pixel,
    output logic                    blur_valid,
    output logic [HCOUNT_WIDTH-1:0] blur_hcount,
    output logic [VCOUNT_WIDTH-1:0] blur_vcount
);

    // window from the line buffer
    logic [3*PIXEL_WIDTH-1:0] row_top;
    logic [3*PIXEL_WIDTH-1:0] row_mid;
    logic [3*PIXEL_WIDTH-1:0] row_bot;
    logic                     window_valid;

    // centre of the current window
    logic [PIXEL_WIDTH-1:0]  center_pixel;
    logic [HCOUNT_WIDTH-1:0] center_hcount;
    logic [VCOUNT_WIDTH-1:0] center_vcount;

    logic [PIXEL_WIDTH-1:0] filtered_pixel;
    logic                   filtered_valid;

    line_buffer u_line_buffer (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid),
        .hcount        (hcount),
        .vcount        (vcount),
        .row_top       (row_top),
        .row_mid       (row_mid),
        .row_bot       (row_bot),
        .window_valid  (window_valid),
        .center_pixel  (center_pixel),
        .center_hcount (center_hcount),
        .center_vcount (center_vcount)
    );

    gaussian_blur u_gaussian_blur (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .row_top        (row_top),
        .row_mid        (row_mid),
        .row_bot        (row_bot),
        .window_valid   (window_valid),
        .filtered_pixel (filtered_pixel),
        .filtered_valid (filtered_valid)
    );

    blur_output_stage u_blur_output_stage (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .window_valid   (window_valid),
        .center_pixel   (center_pixel),
        .center_hcount  (center_hcount),
        .center_vcount  (center_vcount),
        .filtered_pixel (filtered_pixel),
        .filtered_valid (filtered_valid),
        .blur_pixel     (blur_pixel),
        .blur_valid     (blur_valid),
        .blur_hcount    (blur_hcount),
        .blur_vcount    (blur_vcount)
    );

endmodule

//--- hdl/blur_output_stage.sv
// blur_output_stage: centre pixel and coordinate delay line with raw or blurred selection

`timescale 1ns/10ps

module blur_output_stage import video_pkg::*, filter_pkg::*; (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  logic                    window_valid,
    input  logic [PIXEL_WIDTH-1:0]  center_pixel,
    input  logic [HCOUNT_WIDTH-1:0] center_hcount,
    input  logic [VCOUNT_WIDTH-1:0] center_vcount,
    input  logic [PIXEL_WIDTH-1:0]  filtered_pixel,
    input  logic                    filtered_valid,
    output logic [PIXEL_WIDTH-1:0]  blur_pixel,
    output logic                    blur_valid,
    output logic [HCOUNT_WIDTH-1:0] blur_hcount,
    output logic [VCOUNT_WIDTH-1:0] blur_vcount
);

    localparam int LAST = BLUR_LATENCY - 1;

    // delay line matched to the filter pipeline
    logic [PIXEL_WIDTH-1:0]  pixel_d  [BLUR_LATENCY];
    logic [HCOUNT_WIDTH-1:0] hcount_d [BLUR_LATENCY];
    logic [VCOUNT_WIDTH-1:0] vcount_d [BLUR_LATENCY];
    logic [BLUR_LATENCY-1:0] border_d;

    always_ff @(posedge clk_in) begin
        pixel_d[0]  <= center_pixel;
        hcount_d[0] <= center_hcount;
        vcount_d[0] <= center_vcount;
        // window around a first-column or first-row centre reaches outside the frame
        border_d[0] <= (center_hcount == '0) || (center_vcount == '0);
        for (int k = 1; k < BLUR_LATENCY; k++) begin
            pixel_d[k]  <= pixel_d[k-1];
            hcount_d[k] <= hcount_d[k-1];
            vcount_d[k] <= vcount_d[k-1];
            border_d[k] <= border_d[k-1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            blur_valid <= 1'b0;
        end else begin
            blur_valid <= filtered_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        if (filtered_valid) begin
            blur_pixel  <= border_d[LAST] ? pixel_d[LAST] : filtered_pixel;
            blur_hcount <= hcount_d[LAST];
            blur_vcount <= vcount_d[LAST];
        end
    end

endmodule

//--- hdl/gaussian_blur.sv
// gaussian_blur: four-stage multiply, register, accumulate and shift pipeline over a 3x3 window

`timescale 1ns/10ps

module gaussian_blur import video_pkg::*, filter_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic [3*PIXEL_WIDTH-1:0] row_top,
    input  logic [3*PIXEL_WIDTH-1:0] row_mid,
    input  logic [3*PIXEL_WIDTH-1:0] row_bot,
    input  logic                     window_valid,
    output logic [PIXEL_WIDTH-1:0]   filtered_pixel,
    output logic                     filtered_valid
);

    logic [KERNEL_TAPS*PIXEL_WIDTH-1:0] window;
    logic [PIXEL_WIDTH-1:0]             taps [KERNEL_TAPS];

    // stage 1 multiply
    logic [PRODUCT_WIDTH-1:0] product [KERNEL_TAPS];
    logic                     product_valid;

    // stage 2 extra register in front of the adder tree
    logic [PRODUCT_WIDTH-1:0] product_q [KERNEL_TAPS];
    logic                     product_q_valid;

    // stage 3 accumulate
    logic [SUM_WIDTH-1:0] sum_comb;
    logic [SUM_WIDTH-1:0] sum_q;
    logic                 sum_valid;

    assign window = {row_top, row_mid, row_bot};

    // tap 0 is the top-left pixel, same order as the weights
    always_comb begin
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            taps[i] = window[(KERNEL_TAPS-1-i)*PIXEL_WIDTH +: PIXEL_WIDTH];
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            product[i] <= PRODUCT_WIDTH'(KERNEL_WEIGHTS[i]) * PRODUCT_WIDTH'(taps[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            product_q[i] <= product[i];
        end
    end

    // nine products fit in SUM_WIDTH since the weights total 16
    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            sum_comb = sum_comb + SUM_WIDTH'(product_q[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        sum_q <= sum_comb;
    end

    // divide by 16, truncating
    always_ff @(posedge clk_in) begin
        filtered_pixel <= PIXEL_WIDTH'(sum_q >> KERNEL_SHIFT);
    end

    // valid rides alongside the data through all four stages
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            product_valid   <= 1'b0;
            product_q_valid <= 1'b0;
            sum_valid       <= 1'b0;
            filtered_valid  <= 1'b0;
        end else begin
            product_valid   <= window_valid;
            product_q_valid <= product_valid;
            sum_valid       <= product_q_valid;
            filtered_valid  <= sum_valid;
        end
    end

endmodule

//--- hdl/line_buffer.sv
// line_buffer: two row memories and a 3x3 window register issuing one window per pixel

`timescale 1ns/10ps

module line_buffer import video_pkg::*; (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic [PIXEL_WIDTH-1:0]   pixel,
    input  logic                     pixel_valid,
    input  logic [HCOUNT_WIDTH-1:0]  hcount,
    input  logic [VCOUNT_WIDTH-1:0]  vcount,
    output logic [3*PIXEL_WIDTH-1:0] row_top,
    output logic [3*PIXEL_WIDTH-1:0] row_mid,
    output logic [3*PIXEL_WIDTH-1:0] row_bot,
    output logic                     window_valid,
    output logic [PIXEL_WIDTH-1:0]   center_pixel,
    output logic [HCOUNT_WIDTH-1:0]  center_hcount,
    output logic [VCOUNT_WIDTH-1:0]  center_vcount
);

    // row two back and row one back, indexed by column
    logic [PIXEL_WIDTH-1:0] row_old [H_ACTIVE];
    logic [PIXEL_WIDTH-1:0] row_new [H_ACTIVE];

    // memory reads at the incoming column
    logic [PIXEL_WIDTH-1:0] tap_top;
    logic [PIXEL_WIDTH-1:0] tap_mid;

    // window columns, index 0 is the leftmost
    logic [PIXEL_WIDTH-1:0] win_top [3];
    logic [PIXEL_WIDTH-1:0] win_mid [3];
    logic [PIXEL_WIDTH-1:0] win_bot [3];

    logic qualify;

    assign tap_top = row_old[hcount];
    assign tap_mid = row_new[hcount];

    // the window is complete once a full row and column lie behind the pixel
    assign qualify = pixel_valid && (hcount != '0) && (vcount != '0);

    // rows age by one on every strobe at this column
    always_ff @(posedge clk_in) begin
        if (pixel_valid) begin
            row_old[hcount] <= tap_mid;
            row_new[hcount] <= pixel;
        end
    end

    // slide the window one column to the left per strobe
    always_ff @(posedge clk_in) begin
        if (pixel_valid) begin
            for (int c = 0; c < 2; c++) begin
                win_top[c] <= win_top[c+1];
                win_mid[c] <= win_mid[c+1];
                win_bot[c] <= win_bot[c+1];
            end
            win_top[2] <= tap_top;
            win_mid[2] <= tap_mid;
            win_bot[2] <= pixel;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= qualify;
        end
    end

    // centre sits one column left and one row up from the incoming pixel
    always_ff @(posedge clk_in) begin
        if (qualify) begin
            center_hcount <= hcount - HCOUNT_WIDTH'(1);
            center_vcount <= vcount - VCOUNT_WIDTH'(1);
        end
    end

    // left pixel in the top bits of each row bus
    assign row_top = {win_top[0], win_top[1], win_top[2]};
    assign row_mid = {win_mid[0], win_mid[1], win_mid[2]};
    assign row_bot = {win_bot[0], win_bot[1], win_bot[2]};

    assign center_pixel = win_mid[1];

endmodule

//--- hdl/filter_pkg.sv
// filter_pkg: 3x3 gaussian kernel weights, normalising shift, datapath widths and latency

package filter_pkg;

    // taps in a 3x3 window
    localparam int KERNEL_TAPS = 9;
    localparam int WEIGHT_WIDTH = 8;

    // 1-2-1 / 2-4-2 / 1-2-1 in row-major order, top-left first
    localparam logic [WEIGHT_WIDTH-1:0] KERNEL_WEIGHTS [KERNEL_TAPS] = '{
        8'd1, 8'd2, 8'd1,
        8'd2, 8'd4, 8'd2,
        8'd1, 8'd2, 8'd1
    };

    // weights add up to 16
    localparam int KERNEL_SHIFT = 4;

    // one weighted pixel and the sum of all nine
    localparam int PRODUCT_WIDTH = video_pkg::PIXEL_WIDTH + 3;
    localparam int SUM_WIDTH = video_pkg::PIXEL_WIDTH + 4;

    // window strobe to filtered strobe
    localparam int BLUR_LATENCY = 4;

endpackage

//--- hdl/video_pkg.sv
// video_pkg: greyscale pixel width and active frame geometry with counter widths

package video_pkg;

    // bits per greyscale pixel
    localparam int PIXEL_WIDTH = 8;

    // active frame size in pixels and rows
    localparam int H_ACTIVE = 16;
    localparam int V_ACTIVE = 8;

    // column and row counter widths, sized from the frame geometry
    localparam int HCOUNT_WIDTH = $clog2(H_ACTIVE);
    localparam int VCOUNT_WIDTH = $clog2(V_ACTIVE);

endpackage
